//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_vga_sprite
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- anim_fsm.sv
`timescale 1ns/1ps

module anim_fsm (
    input  logic       clk,
    input  logic       rst_n,
    pixel_bus_if.sink  pix,
    input  logic [7:0] anim_period,
    input  logic       anim_pause,
    output logic       frame_sel
);

    vga_pkg::anim_state_t state;
    vga_pkg::anim_state_t state_nxt;
    logic [7:0]           cnt;
    logic [7:0]           cnt_nxt;
    logic [7:0]           period;
    logic                 period_done;

    assign period      = (anim_period == 8'd0) ? 8'd1 : anim_period; // 0 acts as 1
    assign period_done = (cnt + 8'd1) >= period;

    always_comb begin
        state_nxt = state;
        cnt_nxt   = cnt;
        if (pix.frame_end) begin
            case (state)
                vga_pkg::ANIM_SHOW0: begin
                    if (anim_pause) begin
                        state_nxt = vga_pkg::ANIM_HOLD0;
                    end else if (period_done) begin
                        state_nxt = vga_pkg::ANIM_SHOW1;
                        cnt_nxt   = '0;
                    end else begin
                        cnt_nxt = cnt + 8'd1;
                    end
                end
                vga_pkg::ANIM_SHOW1: begin
                    if (anim_pause) begin
                        state_nxt = vga_pkg::ANIM_HOLD1;
                    end else if (period_done) begin
                        state_nxt = vga_pkg::ANIM_SHOW0;
                        cnt_nxt   = '0;
                    end else begin
                        cnt_nxt = cnt + 8'd1;
                    end
                end
                vga_pkg::ANIM_HOLD0: begin
                    if (!anim_pause) begin
                        state_nxt = vga_pkg::ANIM_SHOW0;
                        cnt_nxt   = '0; // resume from a fresh count
                    end
                end
                default: begin
                    if (!anim_pause) begin
                        state_nxt = vga_pkg::ANIM_SHOW1;
                        cnt_nxt   = '0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= vga_pkg::ANIM_SHOW0;
            cnt   <= '0;
        end else begin
            state <= state_nxt;
            cnt   <= cnt_nxt;
        end
    end

    assign frame_sel = (state == vga_pkg::ANIM_SHOW1) || (state == vga_pkg::ANIM_HOLD1);

endmodule

//--- pixel_bus_if.sv
`timescale 1ns/1ps

interface pixel_bus_if;

    vga_pkg::coord_t x;
    vga_pkg::coord_t y;
    logic            active;    // inside visible area
    logic            hsync;
    logic            vsync;
    logic            frame_end; // last pixel of the frame

    modport timer (
        output x, y, active, hsync, vsync, frame_end
    );

    modport sink (
        input x, y, active, hsync, vsync, frame_end
    );

endinterface

//--- pixel_mux.sv
`timescale 1ns/1ps

`include "vga_defs.svh"

module pixel_mux (
    input  logic              clk,
    input  logic              rst_n,
    pixel_bus_if.sink         pix,
    input  vga_pkg::coord_t   sprite_x,
    input  vga_pkg::coord_t   sprite_y,
    input  logic [1:0]        scale,
    input  vga_pkg::rgb_t     bg_rgb,
    input  vga_pkg::rgb_t     pal_rgb,
    input  vga_pkg::pal_idx_t pix_idx,
    output logic [2:0]        bmp_row,
    output logic [2:0]        bmp_col,
    output vga_pkg::pal_idx_t pal_idx,
    output logic [7:0]        vga_pmod
);

    vga_pkg::coord_t side;
    vga_pkg::coord_t dx;
    vga_pkg::coord_t dy;
    vga_pkg::coord_t col_full;
    vga_pkg::coord_t row_full;
    logic            hit;
    vga_pkg::rgb_t   rgb_nxt;
    vga_pkg::rgb_t   rgb;
    logic            hsync_d;
    logic            vsync_d;

    assign side = vga_pkg::coord_t'(`SPRITE_DIM) << scale;
    assign dx   = pix.x - sprite_x; // only meaningful when x >= sprite_x
    assign dy   = pix.y - sprite_y;
    assign hit  = (pix.x >= sprite_x) && (dx < side) && (pix.y >= sprite_y) && (dy < side);

    assign col_full = dx >> scale;
    assign row_full = dy >> scale;
    assign bmp_col  = col_full[2:0];
    assign bmp_row  = row_full[2:0];
    assign pal_idx  = pix_idx;

    always_comb begin
        if (!pix.active) begin
            rgb_nxt = '0; // blanking
        end else if (hit) begin
            rgb_nxt = pal_rgb;
        end else begin
            rgb_nxt = bg_rgb;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rgb     <= '0;
            hsync_d <= 1'b1;
            vsync_d <= 1'b1;
        end else begin
            rgb     <= rgb_nxt;
            hsync_d <= pix.hsync;
            vsync_d <= pix.vsync;
        end
    end

    // pmod packing: low colour bits in the upper nibble
    assign vga_pmod = {hsync_d, rgb[0], rgb[2], rgb[4], vsync_d, rgb[1], rgb[3], rgb[5]};

endmodule

//--- scan_timer.sv
`timescale 1ns/1ps

module scan_timer #(
    parameter int h_active = 640,
    parameter int h_front  = 16,
    parameter int h_sync   = 96,
    parameter int h_back   = 48,
    parameter int v_active = 480,
    parameter int v_front  = 10,
    parameter int v_sync   = 2,
    parameter int v_back   = 33
) (
    input logic        clk,
    input logic        rst_n,
    pixel_bus_if.timer pix
);

    localparam vga_pkg::coord_t h_vis   = vga_pkg::coord_t'(h_active);
    localparam vga_pkg::coord_t v_vis   = vga_pkg::coord_t'(v_active);
    localparam vga_pkg::coord_t h_last  = vga_pkg::coord_t'(h_active + h_front + h_sync + h_back - 1);
    localparam vga_pkg::coord_t v_last  = vga_pkg::coord_t'(v_active + v_front + v_sync + v_back - 1);
    localparam vga_pkg::coord_t hs_from = vga_pkg::coord_t'(h_active + h_front);
    localparam vga_pkg::coord_t hs_to   = vga_pkg::coord_t'(h_active + h_front + h_sync);
    localparam vga_pkg::coord_t vs_from = vga_pkg::coord_t'(v_active + v_front);
    localparam vga_pkg::coord_t vs_to   = vga_pkg::coord_t'(v_active + v_front + v_sync);

    vga_pkg::coord_t x;
    vga_pkg::coord_t y;
    vga_pkg::coord_t x_nxt;
    vga_pkg::coord_t y_nxt;
    logic            hsync;
    logic            vsync;

    always_comb begin
        x_nxt = x + 1'b1;
        y_nxt = y;
        if (x == h_last) begin
            x_nxt = '0;
            y_nxt = (y == v_last) ? '0 : y + 1'b1;
        end
    end

    // syncs come from the next position so they stay aligned with x and y
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x     <= '0;
            y     <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            x     <= x_nxt;
            y     <= y_nxt;
            hsync <= !(x_nxt >= hs_from && x_nxt < hs_to);
            vsync <= !(y_nxt >= vs_from && y_nxt < vs_to);
        end
    end

    assign pix.x         = x;
    assign pix.y         = y;
    assign pix.hsync     = hsync;
    assign pix.vsync     = vsync;
    assign pix.active    = (x < h_vis) && (y < v_vis);
    assign pix.frame_end = (x == h_last) && (y == v_last);

endmodule

//--- sprite_regfile.sv
`timescale 1ns/1ps

`include "vga_defs.svh"

module sprite_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  vga_pkg::wb_adr_t  wb_adr,
    input  vga_pkg::wb_dat_t  wb_dat_w,
    output vga_pkg::wb_dat_t  wb_dat_r,
    output logic              wb_ack,
    input  logic [2:0]        bmp_row,
    input  logic [2:0]        bmp_col,
    input  logic              frame_sel,
    output vga_pkg::pal_idx_t pix_idx,
    input  vga_pkg::pal_idx_t pal_idx,
    output vga_pkg::rgb_t     pal_rgb,
    output vga_pkg::rgb_t     bg_rgb,
    output vga_pkg::coord_t   sprite_x,
    output vga_pkg::coord_t   sprite_y,
    output logic [1:0]        scale,
    output logic [7:0]        anim_period,
    output logic              anim_pause
);

    vga_pkg::rgb_t     pal [16];
    vga_pkg::pal_idx_t bmp [128]; // {frame, row, col}

    vga_pkg::wb_dat_t rd_data;
    logic             req;
    logic             wr;
    logic             pal_hit;
    logic             bmp_hit;
    logic [6:0]       bmp_adr;

    assign req     = wb_cyc && wb_stb && !wb_ack;
    assign wr      = req && wb_we;
    assign pal_hit = (wb_adr & 8'hF0) == `PAL_BASE;
    assign bmp_hit = ((wb_adr & 8'hC0) == `FRAME0_BASE) || ((wb_adr & 8'hC0) == `FRAME1_BASE);
    assign bmp_adr = {wb_adr[7], wb_adr[5:0]}; // bit 7 tells frame 1 from frame 0

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sprite_x    <= '0;
            sprite_y    <= '0;
            scale       <= '0;
            anim_period <= '0;
            anim_pause  <= 1'b0;
            bg_rgb      <= '0;
        end else if (wr) begin
            case (wb_adr)
                `REG_SPRITE_X: sprite_x <= wb_dat_w[9:0];
                `REG_SPRITE_Y: sprite_y <= wb_dat_w[9:0];
                `REG_SCALE:    scale    <= wb_dat_w[1:0];
                `REG_ANIM: begin
                    anim_period <= wb_dat_w[7:0];
                    anim_pause  <= wb_dat_w[8];
                end
                `REG_BG:       bg_rgb   <= wb_dat_w[5:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr && pal_hit) begin
            pal[wb_adr[3:0]] <= wb_dat_w[5:0];
        end
        if (wr && bmp_hit) begin
            bmp[bmp_adr] <= wb_dat_w[3:0];
        end
    end

    always_comb begin
        rd_data = '0; // unmapped reads as zero
        if (pal_hit) begin
            rd_data = vga_pkg::wb_dat_t'(pal[wb_adr[3:0]]);
        end else if (bmp_hit) begin
            rd_data = vga_pkg::wb_dat_t'(bmp[bmp_adr]);
        end else begin
            case (wb_adr)
                `REG_SPRITE_X: rd_data = vga_pkg::wb_dat_t'(sprite_x);
                `REG_SPRITE_Y: rd_data = vga_pkg::wb_dat_t'(sprite_y);
                `REG_SCALE:    rd_data = vga_pkg::wb_dat_t'(scale);
                `REG_ANIM:     rd_data = vga_pkg::wb_dat_t'({anim_pause, anim_period});
                `REG_BG:       rd_data = vga_pkg::wb_dat_t'(bg_rgb);
                default:       rd_data = '0;
            endcase
        end
    end

    // captured with the request so it is valid while ack is high
    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= rd_data;
        end
    end

    assign pix_idx = bmp[{frame_sel, bmp_row, bmp_col}];
    assign pal_rgb = pal[pal_idx];

endmodule

//--- tb_vga_sprite.sv
`timescale 1ns/1ps

module tb_vga_sprite;

    localparam int h_active     = 40;
    localparam int h_front      = 4;
    localparam int h_sync       = 4;
    localparam int h_back       = 4;
    localparam int v_active     = 24;
    localparam int v_front      = 2;
    localparam int v_sync       = 2;
    localparam int v_back       = 2;
    localparam int h_total      = h_active + h_front + h_sync + h_back;
    localparam int frame_cycles = h_total * (v_active + v_front + v_sync + v_back);

    logic             clk;
    logic             rst_n;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    vga_pkg::wb_adr_t wb_adr;
    vga_pkg::wb_dat_t wb_dat_w;
    vga_pkg::wb_dat_t wb_dat_r;
    logic             wb_ack;
    logic [7:0]       vga_pmod;

    byte op_kind[$];
    int  op_a[$];
    int  op_b[$];
    int  op_c[$];
    int  op_d[$];
    int  max_frame = 0;
    bit  ops_ready = 1'b0;
    int  shown     = -1; // raster index now on vga_pmod, -1 while in reset

    vga_sprite_top #(
        .h_active (h_active),
        .h_front  (h_front),
        .h_sync   (h_sync),
        .h_back   (h_back),
        .v_active (v_active),
        .v_front  (v_front),
        .v_sync   (v_sync),
        .v_back   (v_back)
    ) vga_sprite_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .vga_pmod (vga_pmod)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // pixel n of the raster reaches the pmod n+1 edges after reset release
    always @(posedge clk) begin
        if (!rst_n) begin
            shown <= -1;
        end else begin
            shown <= shown + 1;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error at time %0t: %s is %0h, expected %0h",
                                $time, name, got, exp));
        end
    endtask

    task automatic load_golden();
        int    fd;
        int    code;
        int    need;
        byte   kind;
        int    a;
        int    b;
        int    c;
        int    d;
        string rest;
        fd = $fopen("vga_sprite_golden.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open vga_sprite_golden.txt");
        end
        while ($fscanf(fd, " %c", kind) == 1) begin
            a = 0;
            b = 0;
            c = 0;
            d = 0;
            if (kind == "#") begin
                code = $fgets(rest, fd);
                continue;
            end
            if (kind == "P") begin
                need = 4;
                code = $fscanf(fd, "%d %d %d %h", a, b, c, d);
                if (a > max_frame) begin
                    max_frame = a;
                end
            end else if (kind == "W" || kind == "R") begin
                need = 2;
                code = $fscanf(fd, "%h %h", a, b);
            end else begin
                abort_run($sformatf("unknown line kind %c in the golden file", kind));
            end
            if (code != need) begin
                abort_run("malformed line in the golden file");
            end
            op_kind.push_back(kind);
            op_a.push_back(a);
            op_b.push_back(b);
            op_c.push_back(c);
            op_d.push_back(d);
        end
        $fclose(fd);
    endtask

    task automatic wb_access(input logic we, input vga_pkg::wb_adr_t adr,
                             input vga_pkg::wb_dat_t dat, output vga_pkg::wb_dat_t rdata);
        int waited;
        @(posedge clk);
        #2;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        waited   = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 8) begin
                abort_run($sformatf("no wb_ack for the access to address %02h", adr));
            end
        end while (wb_ack !== 1'b1);
        check("wb_ack latency", waited, 1);
        rdata = wb_dat_r;
        @(posedge clk); // master drops the cycle after sampling ack
        #2;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic expect_pixel(input int frame, input int x, input int y, input logic [7:0] exp);
        int target;
        target = frame * frame_cycles + y * h_total + x;
        @(negedge clk);
        if (shown > target) begin
            abort_run($sformatf("pixel (%0d,%0d) of frame %0d passed before it was checked",
                                x, y, frame));
        end
        while (shown < target) begin
            @(negedge clk);
        end
        check($sformatf("vga_pmod at frame %0d (%0d,%0d)", frame, x, y), vga_pmod, exp);
    endtask

    always @(negedge clk) begin : sync_monitor
        int   pos;
        int   px;
        int   py;
        logic hs_exp;
        logic vs_exp;
        hs_exp = 1'b1; // both high in reset
        vs_exp = 1'b1;
        if (shown >= 0) begin
            pos    = shown % frame_cycles;
            px     = pos % h_total;
            py     = pos / h_total;
            hs_exp = !(px >= h_active + h_front && px < h_active + h_front + h_sync);
            vs_exp = !(py >= v_active + v_front && py < v_active + v_front + v_sync);
        end
        check("vga_pmod[7] hsync", vga_pmod[7], hs_exp);
        check("vga_pmod[3] vsync", vga_pmod[3], vs_exp);
        if (vga_sprite_top_i.vga_sprite_chk_i.err_cnt != 0) begin
            abort_run("a bound assertion on the DUT failed");
        end
    end

    initial begin
        wait (ops_ready);
        repeat ((max_frame + 1 + 2) * frame_cycles) @(posedge clk); // frames in file plus two
        abort_run("watchdog expired before the golden file was worked through");
    end

    initial begin
        vga_pkg::wb_dat_t rdata;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        load_golden();
        ops_ready = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int i = 0; i < op_kind.size(); i++) begin
            case (op_kind[i])
                "W": begin
                    wb_access(1'b1, vga_pkg::wb_adr_t'(op_a[i]), vga_pkg::wb_dat_t'(op_b[i]), rdata);
                end
                "R": begin
                    wb_access(1'b0, vga_pkg::wb_adr_t'(op_a[i]), '0, rdata);
                    check($sformatf("wb_dat_r from %02h", op_a[i]), rdata, op_b[i]);
                end
                default: begin
                    expect_pixel(op_a[i], op_b[i], op_c[i], op_d[i][7:0]);
                end
            endcase
        end
        @(negedge clk);
        if (vga_sprite_top_i.vga_sprite_chk_i.err_cnt != 0) begin
            abort_run("a bound assertion on the DUT failed");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

//--- verilog.f
+incdir+.
vga_pkg.sv
pixel_bus_if.sv
scan_timer.sv
anim_fsm.sv
sprite_regfile.sv
pixel_mux.sv
vga_sprite_top.sv
vga_sprite_chk.sv
tb_vga_sprite.sv

//--- vga_defs.svh
`ifndef VGA_DEFS_SVH
`define VGA_DEFS_SVH

// default 640x480 timing
`define VGA_H_ACTIVE 640
`define VGA_H_FRONT  16
`define VGA_H_SYNC   96
`define VGA_H_BACK   48

`define VGA_V_ACTIVE 480
`define VGA_V_FRONT  10
`define VGA_V_SYNC   2
`define VGA_V_BACK   33

`define SPRITE_DIM 8 // bitmap side in pixels

// wishbone word address map
`define REG_SPRITE_X 8'h00
`define REG_SPRITE_Y 8'h01
`define REG_SCALE    8'h02
`define REG_ANIM     8'h03
`define REG_BG       8'h04
`define PAL_BASE     8'h10
`define FRAME0_BASE  8'h40
`define FRAME1_BASE  8'h80

`define WB_ADR_W 8
`define WB_DAT_W 16

`endif

//--- vga_pkg.sv
`include "vga_defs.svh"

package vga_pkg;

    typedef logic [9:0] coord_t; // raster coordinate

    typedef logic [5:0] rgb_t; // {red, green, blue}, 2 bits each

    typedef logic [3:0] pal_idx_t;

    typedef logic [`WB_ADR_W-1:0] wb_adr_t;

    typedef logic [`WB_DAT_W-1:0] wb_dat_t;

    typedef enum logic [1:0] {
        ANIM_SHOW0,
        ANIM_SHOW1,
        ANIM_HOLD0,
        ANIM_HOLD1
    } anim_state_t;

endpackage

//--- vga_sprite_chk.sv
`timescale 1ns/1ps

module vga_sprite_chk (
    input logic       clk,
    input logic       rst_n,
    input logic       wb_cyc,
    input logic       wb_stb,
    input logic       wb_ack,
    input logic [7:0] vga_pmod
);

    int err_cnt = 0; // polled by the testbench

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
    else begin
        $error("wb_ack high for more than one cycle");
        err_cnt++;
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |-> wb_cyc && wb_stb)
    else begin
        $error("wb_ack without wb_cyc and wb_stb");
        err_cnt++;
    end

    // hsync is bit 7, vsync bit 3
    sync_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> vga_pmod[7] && vga_pmod[3])
    else begin
        $error("sync low in the first cycle after reset");
        err_cnt++;
    end

endmodule

bind vga_sprite_top vga_sprite_chk vga_sprite_chk_i (.*);

//--- vga_sprite_golden.txt
# W adr data | R adr expected | P frame x y pmod
# adr, data and pmod in hex; frame, x and y in decimal; sprite at (8,4)
W 00 0008
W 01 0004
W 03 0002
W 04 ffd5
W 11 0030
W 12 ff0c
W 13 0003
W 40 0001
W 4a 0002
W 80 0003
W 8a 0001
W 05 1234
W 20 00ff
R 00 0008
R 03 0002
R 04 0015
R 12 000c
R 8a 0001
R 05 0000
R 20 0000
P 0 7 4 f8
P 0 8 4 99
P 0 16 4 f8
P 0 41 4 88
P 0 45 4 08
P 0 10 5 aa
P 0 8 12 f8
P 0 20 26 80
P 0 45 27 00
P 1 8 4 99
P 2 8 4 cc
P 2 10 5 99
W 02 0001
R 02 0001
P 3 24 4 f8
P 3 9 5 cc
P 3 13 7 99
P 3 8 20 f8
P 4 9 5 99
W 03 0102
R 03 0102
P 5 9 5 99
P 6 9 5 99
W 03 0002
P 7 9 5 99
P 8 9 5 99
P 9 9 5 cc

//--- vga_sprite_top.sv
`timescale 1ns/1ps

`include "vga_defs.svh"

module vga_sprite_top #(
    parameter int h_active = `VGA_H_ACTIVE,
    parameter int h_front  = `VGA_H_FRONT,
    parameter int h_sync   = `VGA_H_SYNC,
    parameter int h_back   = `VGA_H_BACK,
    parameter int v_active = `VGA_V_ACTIVE,
    parameter int v_front  = `VGA_V_FRONT,
    parameter int v_sync   = `VGA_V_SYNC,
    parameter int v_back   = `VGA_V_BACK
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  vga_pkg::wb_adr_t wb_adr,
    input  vga_pkg::wb_dat_t wb_dat_w,
    output vga_pkg::wb_dat_t wb_dat_r,
    output logic             wb_ack,
    output logic [7:0]       vga_pmod
);

    logic              frame_sel;
    logic [7:0]        anim_period;
    logic              anim_pause;
    logic [2:0]        bmp_row;
    logic [2:0]        bmp_col;
    vga_pkg::pal_idx_t pix_idx;
    vga_pkg::pal_idx_t pal_idx;
    vga_pkg::rgb_t     pal_rgb;
    vga_pkg::rgb_t     bg_rgb;
    vga_pkg::coord_t   sprite_x;
    vga_pkg::coord_t   sprite_y;
    logic [1:0]        scale;

    pixel_bus_if pix_bus ();

    scan_timer #(
        .h_active (h_active),
        .h_front  (h_front),
        .h_sync   (h_sync),
        .h_back   (h_back),
        .v_active (v_active),
        .v_front  (v_front),
        .v_sync   (v_sync),
        .v_back   (v_back)
    ) scan_timer_i (
        .clk   (clk),
        .rst_n (rst_n),
        .pix   (pix_bus.timer)
    );

    anim_fsm anim_fsm_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix         (pix_bus.sink),
        .anim_period (anim_period),
        .anim_pause  (anim_pause),
        .frame_sel   (frame_sel)
    );

    sprite_regfile sprite_regfile_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .bmp_row     (bmp_row),
        .bmp_col     (bmp_col),
        .frame_sel   (frame_sel),
        .pix_idx     (pix_idx),
        .pal_idx     (pal_idx),
        .pal_rgb     (pal_rgb),
        .bg_rgb      (bg_rgb),
        .sprite_x    (sprite_x),
        .sprite_y    (sprite_y),
        .scale       (scale),
        .anim_period (anim_period),
        .anim_pause  (anim_pause)
    );

    pixel_mux pixel_mux_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pix      (pix_bus.sink),
        .sprite_x (sprite_x),
        .sprite_y (sprite_y),
        .scale    (scale),
        .bg_rgb   (bg_rgb),
        .pal_rgb  (pal_rgb),
        .pix_idx  (pix_idx),
        .bmp_row  (bmp_row),
        .bmp_col  (bmp_col),
        .pal_idx  (pal_idx),
        .vga_pmod (vga_pmod)
    );

endmodule
